/* logic/pmp_pkg.sv */
// shared types for the pmp unit
// entry count, cfg byte layout, address modes
// register port and check port payloads
// handshake state encoding

package pmp_pkg;

  // sizing
  localparam int pmp_entries = 8;                 // number of pmp entries
  localparam int pmp_idx_w   = 3;                 // bits to index one entry

  // address matching mode, riscv encoding of pmpcfg.A
  typedef enum logic [1:0] {
    OFF   = 2'd0,                                 // entry disabled
    TOR   = 2'd1,                                 // top of range
    NA4   = 2'd2,                                 // single word
    NAPOT = 2'd3                                  // naturally aligned power of two
  } pmp_addr_mode_e;

  // one pmpcfg byte, msb first
  typedef struct packed {
    logic           L;                            // lock, also binds machine mode
    logic [1:0]     reserved;                     // wpri, always read as zero
    pmp_addr_mode_e A;                            // address mode
    logic           X;                            // execute permission
    logic           W;                            // write permission
    logic           R;                            // read permission
  } pmpcfg_base_t;

  typedef logic [31:0] pmpaddr_t;                 // word address, same units as pmpaddr

  // full tables as seen by the checker
  typedef pmpcfg_base_t [pmp_entries-1:0] pmpcfg_table_t;
  typedef pmpaddr_t     [pmp_entries-1:0] pmpaddr_table_t;

  // access kind of a check
  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,                             // load
    ACC_WRITE = 2'd1,                             // store
    ACC_EXEC  = 2'd2                              // instruction fetch
  } pmp_access_e;

  // privilege of the requester, no supervisor mode
  typedef enum logic {
    PRIV_USER    = 1'b0,
    PRIV_MACHINE = 1'b1
  } pmp_priv_e;

  // register port request
  typedef struct packed {
    logic                 write;                  // 1 write, 0 read
    logic                 is_cfg;                 // 1 cfg byte, 0 addr
    logic [pmp_idx_w-1:0] index;                  // entry selected
    logic [31:0]          wdata;                  // low byte only for cfg
  } pmp_csr_req_t;

  // check port request
  typedef struct packed {
    pmpaddr_t    addr;                            // word address to check
    pmp_access_e access;                          // read, write or exec
    pmp_priv_e   priv;                            // user or machine
  } pmp_chk_req_t;

  // check port result
  typedef struct packed {
    logic                 allowed;                // access granted
    logic                 matched;                // some entry matched
    logic [pmp_idx_w-1:0] entry;                  // winner, zero on no match
  } pmp_chk_rsp_t;

  // four-phase slave state, shared by both port controllers
  typedef enum logic [1:0] {
    HS_IDLE = 2'd0,                               // waiting for req
    HS_WORK = 2'd1,                               // request taken, result pending
    HS_ACK  = 2'd2                                // ack high until req drops
  } pmp_hs_state_e;

endpackage

/* logic/pmp_matcher.sv */
// address matcher for a single pmp entry
// handles OFF, TOR, NA4 and NAPOT modes
// purely combinational

`timescale 1ns/10ps

module pmp_matcher import pmp_pkg::*; (
  input  pmpaddr_t     phys_addr,                 // word address under check
  input  pmpcfg_base_t check_cfg,                 // this entry's cfg byte
  input  pmpaddr_t     cfg_addr,                  // this entry's pmpaddr
  input  pmpaddr_t     cfg_addr_before,           // previous entry's pmpaddr for TOR
  output logic         match                      // entry covers phys_addr
);

  pmpaddr_t napot_mask;                           // bits that must compare equal
  logic     first_zero;                           // first zero of cfg_addr found
  logic     tor_hit;
  logic     napot_hit;

  // napot size is coded as trailing ones in cfg_addr
  // the ones and the first zero above them are don't care bits
  always_comb begin
    napot_mask = '1;
    first_zero = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (!first_zero) begin
        napot_mask[i] = 1'b0;                     // inside the region size
        if (!cfg_addr[i]) begin
          first_zero = 1'b1;                      // stop after the first zero
        end
      end
    end
  end

  // all ones leaves an empty mask, so whole space matches
  assign napot_hit = ((phys_addr ^ cfg_addr) & napot_mask) == '0;

  // inverted or empty range never hits
  assign tor_hit = (cfg_addr_before < cfg_addr) &&
                   (phys_addr >= cfg_addr_before) &&
                   (phys_addr < cfg_addr);

  always_comb begin
    match = 1'b0;
    case (check_cfg.A)
      NA4: begin
        match = (phys_addr == cfg_addr);          // exactly one word
      end
      TOR: begin
        match = tor_hit;
      end
      NAPOT: begin
        match = napot_hit;
      end
      OFF: begin
        match = 1'b0;                             // disabled entry
      end
      default: begin
        match = 1'b0;
      end
    endcase
  end

endmodule

/* logic/pmp_checker.sv */
// permission checker for the pmp unit
// one matcher per entry, lowest index wins
// registered request and result behind a four-phase handshake

`timescale 1ns/10ps

module pmp_checker import pmp_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           chk_req,                 // level request from master
  input  pmp_chk_req_t   chk_cmd,                 // held stable while chk_req high
  output logic           chk_ack,
  output pmp_chk_rsp_t   chk_rsp,                 // valid while chk_ack high
  input  pmpcfg_table_t  cfg_table,               // live cfg bytes
  input  pmpaddr_table_t addr_table               // live addrs
);

  pmp_hs_state_e          state_q;
  pmp_chk_req_t           req_q;                  // captured request
  pmp_chk_rsp_t           rsp_q;                  // captured result
  pmp_chk_rsp_t           rsp_d;
  logic [pmp_entries-1:0] match_vec;              // per entry hit
  pmpaddr_table_t         addr_before;            // lower bound for TOR
  pmpcfg_base_t           win_cfg;                // cfg of winning entry
  logic                   perm_bit;               // R, W or X of winner

  for (genvar gi = 0; gi < pmp_entries; gi++) begin : g_match
    if (gi == 0) begin : g_first
      assign addr_before[gi] = '0;                // entry 0 range starts at zero
    end else begin : g_rest
      assign addr_before[gi] = addr_table[gi-1];
    end

    pmp_matcher i_matcher (
      .phys_addr       (req_q.addr),
      .check_cfg       (cfg_table[gi]),
      .cfg_addr        (addr_table[gi]),
      .cfg_addr_before (addr_before[gi]),
      .match           (match_vec[gi])
    );
  end

  // priority pick and permission decision
  always_comb begin
    rsp_d.matched = 1'b0;
    rsp_d.entry   = '0;
    for (int i = pmp_entries - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        rsp_d.matched = 1'b1;
        rsp_d.entry   = pmp_idx_w'(i);            // last write is the lowest index
      end
    end
    win_cfg = cfg_table[rsp_d.entry];
    case (req_q.access)
      ACC_READ:  perm_bit = win_cfg.R;
      ACC_WRITE: perm_bit = win_cfg.W;
      ACC_EXEC:  perm_bit = win_cfg.X;
      default:   perm_bit = 1'b0;                 // unused encoding
    endcase
    if (rsp_d.matched) begin
      // unlocked entries do not bind machine mode
      rsp_d.allowed = ((req_q.priv == PRIV_MACHINE) && !win_cfg.L) || perm_bit;
    end else begin
      rsp_d.allowed = (req_q.priv == PRIV_MACHINE); // default: machine yes, user no
    end
  end

  // handshake FSM, idle -> work -> ack -> idle
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= HS_IDLE;
    end else begin
      case (state_q)
        HS_IDLE: if (chk_req) state_q <= HS_WORK;  // edge N
        HS_WORK: state_q <= HS_ACK;                // edge N+1
        HS_ACK:  if (!chk_req) state_q <= HS_IDLE;
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == HS_IDLE && chk_req) begin
      req_q <= chk_cmd;                           // take request at edge N
    end
    if (state_q == HS_WORK) begin
      rsp_q <= rsp_d;                             // result at edge N+1
    end
  end

  assign chk_ack = (state_q == HS_ACK);
  assign chk_rsp = rsp_q;

  // result may not move under a held ack
  a_rsp_stable: assert property (@(posedge clk) disable iff (reset)
    chk_ack && $past(chk_ack) |-> $stable(chk_rsp));

endmodule

/* logic/pmp_csr_file.sv */
// pmpcfg and pmpaddr register storage
// lock rules for cfg and addr writes, incl TOR lock of the lower addr
// four-phase register port with one cycle ack latency

`timescale 1ns/10ps

module pmp_csr_file import pmp_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           csr_req,                 // level request from master
  input  pmp_csr_req_t   csr_cmd,                 // held stable while csr_req high
  output logic           csr_ack,
  output logic [31:0]    csr_rdata,               // valid while csr_ack high
  output pmpcfg_table_t  cfg_table,               // to checker
  output pmpaddr_table_t addr_table               // to checker
);

  pmp_hs_state_e          state_q;
  pmpcfg_table_t          cfg_q;                  // eight cfg bytes
  pmpaddr_table_t         addr_q;                 // eight addrs
  logic [31:0]            rdata_q;
  logic [pmp_entries-1:0] cfg_locked;             // cfg write blocked
  logic [pmp_entries-1:0] addr_locked;            // addr write blocked
  pmpcfg_base_t           cfg_wr;                 // cleaned cfg write value
  logic                   accept;                 // request taken this edge

  // lock decode per entry
  for (genvar gi = 0; gi < pmp_entries; gi++) begin : g_lock
    assign cfg_locked[gi] = cfg_q[gi].L;

    if (gi == pmp_entries - 1) begin : g_last
      assign addr_locked[gi] = cfg_q[gi].L;       // no entry above
    end else begin : g_mid
      // a locked TOR entry above also freezes its lower bound
      assign addr_locked[gi] = cfg_q[gi].L |
                               (cfg_q[gi+1].L & (cfg_q[gi+1].A == TOR));
    end

    // lock only clears on reset
    a_lock_hold: assert property (@(posedge clk) disable iff (reset)
      cfg_q[gi].L |=> $stable(cfg_q[gi]));
  end

  always_comb begin
    cfg_wr          = pmpcfg_base_t'(csr_cmd.wdata[7:0]);
    cfg_wr.reserved = 2'b00;                      // wpri bits forced to zero
  end

  assign accept = (state_q == HS_IDLE) && csr_req;

  // handshake FSM and register writes
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= HS_IDLE;
      cfg_q   <= '0;
      addr_q  <= '0;
    end else begin
      case (state_q)
        HS_IDLE: if (csr_req) state_q <= HS_ACK;   // ack one cycle later
        HS_ACK:  if (!csr_req) state_q <= HS_IDLE;
        default: state_q <= HS_IDLE;               // work state unused here
      endcase

      if (accept && csr_cmd.write) begin
        if (csr_cmd.is_cfg) begin
          if (!cfg_locked[csr_cmd.index]) begin
            cfg_q[csr_cmd.index] <= cfg_wr;
          end
        end else begin
          if (!addr_locked[csr_cmd.index]) begin
            addr_q[csr_cmd.index] <= csr_cmd.wdata;
          end
        end
      end
    end
  end

  // read data captured on accept, held through ack
  always_ff @(posedge clk) begin
    if (accept) begin
      if (csr_cmd.is_cfg) begin
        rdata_q <= {24'd0, cfg_q[csr_cmd.index]};  // zero extended cfg byte
      end else begin
        rdata_q <= addr_q[csr_cmd.index];
      end
    end
  end

  assign csr_ack    = (state_q == HS_ACK);
  assign csr_rdata  = rdata_q;
  assign cfg_table  = cfg_q;
  assign addr_table = addr_q;

  // ack only answers a request seen at the edge before
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(csr_ack) |-> $past(csr_req));

endmodule

/* logic/pmp_unit.sv */
// pmp unit top level
// register file feeding the permission checker
// register port and check port brought out unchanged

`timescale 1ns/10ps

module pmp_unit import pmp_pkg::*; (
  input  logic         clk,
  input  logic         reset,

  // register port
  input  logic         csr_req,
  input  pmp_csr_req_t csr_cmd,
  output logic         csr_ack,
  output logic [31:0]  csr_rdata,

  // check port
  input  logic         chk_req,
  input  pmp_chk_req_t chk_cmd,
  output logic         chk_ack,
  output pmp_chk_rsp_t chk_rsp
);

  pmpcfg_table_t  cfg_table;                      // always current cfg bytes
  pmpaddr_table_t addr_table;                     // always current addrs

  pmp_csr_file i_csr_file (
    .clk        (clk),
    .reset      (reset),
    .csr_req    (csr_req),
    .csr_cmd    (csr_cmd),
    .csr_ack    (csr_ack),
    .csr_rdata  (csr_rdata),
    .cfg_table  (cfg_table),
    .addr_table (addr_table)
  );

  pmp_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .chk_req    (chk_req),
    .chk_cmd    (chk_cmd),
    .chk_ack    (chk_ack),
    .chk_rsp    (chk_rsp),
    .cfg_table  (cfg_table),
    .addr_table (addr_table)
  );

endmodule

/* include/pmp_tb_tasks.svh */
// handshake drivers for the register and check ports
// value compare with error count
// directed tests for modes, priority, locking, random and timing

// value compare, counts and reports a mismatch
task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
  if (actual !== expected) begin
    err_count++;
    $display("Error at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
  end
endtask

// wait on negedges until an ack reaches level, bounded
task automatic wait_ack(input bit on_chk, input bit level, output int cycles);
  int n;
  bit seen;
  n    = 0;
  seen = 1'b0;
  while (!seen && n < ack_limit) begin
    @(negedge clk);                               // acks settle after posedge
    n++;
    seen = on_chk ? (chk_ack === level) : (csr_ack === level);
  end
  if (!seen) begin
    timeout_count++;
    $display("timeout at %0t: %s ack never went to %0d", $time, on_chk ? "check" : "register",
             level);
  end
  cycles = n;
endtask

task automatic csr_write(input int idx, input bit is_cfg, input logic [31:0] data);
  @(negedge clk);
  csr_cmd.write  = 1'b1;
  csr_cmd.is_cfg = is_cfg;
  csr_cmd.index  = idx[pmp_idx_w-1:0];
  csr_cmd.wdata  = data;
  csr_req        = 1'b1;
  wait_ack(1'b0, 1'b1, last_rise);
  csr_req = 1'b0;                                 // still on the negedge
  wait_ack(1'b0, 1'b0, last_fall);
  model_write(idx, is_cfg, data);
endtask

task automatic csr_read(input int idx, input bit is_cfg, output logic [31:0] data);
  @(negedge clk);
  csr_cmd.write  = 1'b0;
  csr_cmd.is_cfg = is_cfg;
  csr_cmd.index  = idx[pmp_idx_w-1:0];
  csr_cmd.wdata  = '0;
  csr_req        = 1'b1;
  wait_ack(1'b0, 1'b1, last_rise);
  data    = csr_rdata;                            // valid while ack high
  csr_req = 1'b0;
  wait_ack(1'b0, 1'b0, last_fall);
endtask

task automatic check_access(input pmpaddr_t addr, input pmp_access_e acc, input pmp_priv_e priv,
                            output pmp_chk_rsp_t rsp);
  @(negedge clk);
  chk_cmd.addr   = addr;
  chk_cmd.access = acc;
  chk_cmd.priv   = priv;
  chk_req        = 1'b1;
  wait_ack(1'b1, 1'b1, last_rise);
  rsp     = chk_rsp;
  chk_req = 1'b0;
  wait_ack(1'b1, 1'b0, last_fall);
endtask

// one check against the model
task automatic verify_access(input pmpaddr_t addr, input pmp_access_e acc, input pmp_priv_e priv);
  pmp_chk_rsp_t rsp;
  pmp_chk_rsp_t exp;
  check_access(addr, acc, priv, rsp);
  exp = model_check(addr, acc, priv);
  compare_value($sformatf("chk_rsp.allowed @%0h", addr), exp.allowed, rsp.allowed);
  compare_value($sformatf("chk_rsp.matched @%0h", addr), exp.matched, rsp.matched);
  compare_value($sformatf("chk_rsp.entry @%0h", addr), exp.entry, rsp.entry);
endtask

// all three access kinds, both privileges
task automatic probe_every_kind(input pmpaddr_t addr);
  for (int a = 0; a < 3; a++)
    for (int p = 0; p < 2; p++)
      verify_access(addr, pmp_access_e'(a), pmp_priv_e'(p));
endtask

task automatic check_reset_values();
  logic [31:0] d;
  pmp_chk_rsp_t rsp;
  for (int i = 0; i < pmp_entries; i++) begin
    csr_read(i, 1'b1, d);
    compare_value($sformatf("pmpcfg%0d", i), 32'd0, d);
    csr_read(i, 1'b0, d);
    compare_value($sformatf("pmpaddr%0d", i), 32'd0, d);
  end
  check_access(32'h1234, ACC_READ, PRIV_USER, rsp);
  compare_value("chk_rsp.allowed user", 1'b0, rsp.allowed);    // nothing matches
  compare_value("chk_rsp.matched user", 1'b0, rsp.matched);
  check_access(32'h1234, ACC_WRITE, PRIV_MACHINE, rsp);
  compare_value("chk_rsp.allowed machine", 1'b1, rsp.allowed);
endtask

task automatic sweep_mode_regions();
  csr_write(1, 1'b0, 32'h100);
  csr_write(1, 1'b1, cfg_byte(0, NA4, 0, 0, 1));
  csr_write(2, 1'b0, 32'h200);                    // TOR 0x100 up to 0x1ff
  csr_write(2, 1'b1, cfg_byte(0, TOR, 0, 1, 1));
  csr_write(3, 1'b0, 32'h1003);                   // NAPOT 8 words at 0x1000
  csr_write(3, 1'b1, cfg_byte(0, NAPOT, 1, 0, 0));
  probe_every_kind(32'h0ff);
  probe_every_kind(32'h100);
  probe_every_kind(32'h101);
  probe_every_kind(32'h1ff);
  probe_every_kind(32'h200);
  probe_every_kind(32'h0fff);
  probe_every_kind(32'h1000);
  probe_every_kind(32'h1007);
  probe_every_kind(32'h1008);
  csr_write(3, 1'b0, 32'h10ff);                   // 512 words at 0x1000
  probe_every_kind(32'h11ff);
  probe_every_kind(32'h1200);
  csr_write(3, 1'b0, 32'hffff_ffff);              // whole space
  probe_every_kind(32'h5000);
  probe_every_kind(32'hdead_beef);
  csr_write(2, 1'b0, 32'h80);                     // TOR now inverted
  probe_every_kind(32'h90);
  probe_every_kind(32'h150);
  csr_write(3, 1'b0, 32'h10ff);
endtask

task automatic check_priority_rules();
  pmp_chk_rsp_t rsp;
  csr_write(5, 1'b0, 32'h200f);                   // 0x2000..0x201f, exec only
  csr_write(5, 1'b1, cfg_byte(0, NAPOT, 1, 0, 0));
  csr_write(6, 1'b0, 32'h203f);                   // 0x2000..0x207f, read write
  csr_write(6, 1'b1, cfg_byte(0, NAPOT, 0, 1, 1));
  probe_every_kind(32'h2004);
  probe_every_kind(32'h2050);
  probe_every_kind(32'h2080);
  check_access(32'h2004, ACC_WRITE, PRIV_USER, rsp);
  compare_value("chk_rsp.entry overlap", 3'd5, rsp.entry);
  compare_value("chk_rsp.allowed user write", 1'b0, rsp.allowed);
  check_access(32'h2004, ACC_WRITE, PRIV_MACHINE, rsp);
  compare_value("chk_rsp.allowed machine write", 1'b1, rsp.allowed);
endtask

task automatic exercise_locking();
  logic [31:0] d;
  pmp_chk_rsp_t rsp;
  csr_write(4, 1'b0, 32'h1800);                   // TOR from addr3 up to 0x17ff
  csr_write(4, 1'b1, cfg_byte(1, TOR, 0, 0, 1));
  csr_write(4, 1'b1, 32'h07);
  csr_write(4, 1'b0, 32'h9999);
  csr_write(3, 1'b0, 32'h5555);
  csr_read(4, 1'b1, d);
  compare_value("pmpcfg4", cfg_byte(1, TOR, 0, 0, 1), d);
  csr_read(4, 1'b0, d);
  compare_value("pmpaddr4", 32'h1800, d);
  csr_read(3, 1'b0, d);
  compare_value("pmpaddr3", 32'h10ff, d);
  check_access(32'h1500, ACC_WRITE, PRIV_MACHINE, rsp);
  compare_value("chk_rsp.entry locked", 3'd4, rsp.entry);
  compare_value("chk_rsp.allowed locked write", 1'b0, rsp.allowed);
  probe_every_kind(32'h1500);
endtask

task automatic run_random_checks();
  logic [31:0] r;
  pmpaddr_t    addr;
  for (int n = 0; n < 40; n++) begin
    r    = $random(seed);
    addr = $random(seed) & 32'h0000_3fff;         // keep near programmed regions
    verify_access(addr, (r[1:0] == 2'd3) ? ACC_READ : pmp_access_e'(r[1:0]), pmp_priv_e'(r[2]));
  end
endtask

task automatic measure_ack_timing();
  pmp_chk_rsp_t rsp;
  check_access(32'h2004, ACC_READ, PRIV_USER, rsp);
  compare_value("chk_ack rise latency", 2, last_rise);
  compare_value("chk_ack fall latency", 1, last_fall);
  csr_write(0, 1'b0, 32'h0);
  compare_value("csr_ack rise latency", 1, last_rise);
  compare_value("csr_ack fall latency", 1, last_fall);
endtask

/* verif/pmp_unit_tb.sv */
// testbench for the pmp unit
// clock, reset, DUT instance
// reference model of the match, priority and permission rules
// directed test sequence and closing summary

`timescale 1ns/10ps

module pmp_unit_tb import pmp_pkg::*; ();

  logic         clk;
  logic         reset;
  logic         csr_req;
  pmp_csr_req_t csr_cmd;
  logic         csr_ack;
  logic [31:0]  csr_rdata;
  logic         chk_req;
  pmp_chk_req_t chk_cmd;
  logic         chk_ack;
  pmp_chk_rsp_t chk_rsp;

  int           err_count;
  int           timeout_count;
  int           ack_limit = 20;                   // cycles before a wait gives up
  int           last_rise;                        // req high to ack high, in cycles
  int           last_fall;                        // req low to ack low, in cycles
  integer       seed;
  pmpcfg_base_t model_cfg  [pmp_entries];         // what the DUT should hold
  pmpaddr_t     model_addr [pmp_entries];

  pmp_unit i_pmp_unit (
    .clk       (clk),
    .reset     (reset),
    .csr_req   (csr_req),
    .csr_cmd   (csr_cmd),
    .csr_ack   (csr_ack),
    .csr_rdata (csr_rdata),
    .chk_req   (chk_req),
    .chk_cmd   (chk_cmd),
    .chk_ack   (chk_ack),
    .chk_rsp   (chk_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                        // 4 ns period
  end

  // cfg byte from its fields, L first
  function automatic logic [7:0] cfg_byte(bit l, pmp_addr_mode_e a, bit x, bit w, bit r);
    return {l, 2'b00, a, x, w, r};
  endfunction

  // mirror a register write, lock rules included
  function automatic void model_write(int idx, bit is_cfg, logic [31:0] data);
    bit           addr_lock;
    pmpcfg_base_t c;
    addr_lock = model_cfg[idx].L;
    if (idx < pmp_entries - 1 && model_cfg[idx+1].L && model_cfg[idx+1].A == TOR)
      addr_lock = 1'b1;                           // locked TOR above pins this addr
    if (is_cfg) begin
      if (!model_cfg[idx].L) begin
        c          = pmpcfg_base_t'(data[7:0]);
        c.reserved = 2'b00;
        model_cfg[idx] = c;
      end
    end else if (!addr_lock) begin
      model_addr[idx] = data;
    end
  endfunction

  // does entry idx cover word address a
  function automatic bit model_match(int idx, pmpaddr_t a);
    pmpaddr_t base;
    pmpaddr_t prev;
    int       ones;
    bit       hit;
    base = model_addr[idx];
    prev = (idx == 0) ? 32'd0 : model_addr[idx-1];
    hit  = 1'b0;
    case (model_cfg[idx].A)
      NA4: hit = (a == base);
      TOR: hit = (prev < base) && (a >= prev) && (a < base);
      NAPOT: begin
        ones = 0;
        while (ones < 32 && base[ones]) ones++;  // trailing ones give the size
        if (ones >= 31) hit = 1'b1;               // nothing left to compare
        else hit = ((a >> (ones + 1)) == (base >> (ones + 1)));
      end
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

  // lowest matching entry decides
  function automatic pmp_chk_rsp_t model_check(pmpaddr_t a, pmp_access_e acc, pmp_priv_e priv);
    pmp_chk_rsp_t r;
    bit           perm;
    r = '0;
    for (int i = 0; i < pmp_entries; i++) begin
      if (!r.matched && model_match(i, a)) begin
        r.matched = 1'b1;
        r.entry   = i[pmp_idx_w-1:0];
      end
    end
    if (r.matched) begin
      case (acc)
        ACC_READ:  perm = model_cfg[r.entry].R;
        ACC_WRITE: perm = model_cfg[r.entry].W;
        default:   perm = model_cfg[r.entry].X;
      endcase
      r.allowed = ((priv == PRIV_MACHINE) && !model_cfg[r.entry].L) || perm;
    end else begin
      r.allowed = (priv == PRIV_MACHINE);         // default for no match
    end
    return r;
  endfunction

  `include "pmp_tb_tasks.svh"

  initial begin
    reset         = 1'b1;
    csr_req       = 1'b0;
    csr_cmd       = '0;
    chk_req       = 1'b0;
    chk_cmd       = '0;
    err_count     = 0;
    timeout_count = 0;
    seed          = 32'h27d9;
    for (int i = 0; i < pmp_entries; i++) begin
      model_cfg[i]  = '0;
      model_addr[i] = '0;
    end
    repeat (4) @(negedge clk);                    // 4 rising edges in reset
    reset = 1'b0;

    check_reset_values();
    sweep_mode_regions();
    check_priority_rules();
    exercise_locking();
    run_random_checks();
    measure_ack_timing();

    $display("errors %0d timeouts %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
logic/pmp_pkg.sv
logic/pmp_matcher.sv
logic/pmp_checker.sv
logic/pmp_csr_file.sv
logic/pmp_unit.sv
verif/pmp_unit_tb.sv
